//--- sources.f
common/cpu_pkg.sv
datapath/alu.sv
datapath/datapath.sv
control/control_unit.sv
source/wb_master.sv
source/cpu_top.sv
verif/wb_memory.sv
verif/tb_cpu.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_cpu -f sources.f \
	&& ./obj_dir/Vtb_cpu 2>&1 | tee sim.log \
	&& grep -qx "PASS: all tests" sim.log \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed, check sim.log"; exit 1; }

//--- verif/tb_cpu.sv
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MEM_WORDS = 1024;
	localparam int TIMEOUT_CYCLES = 5000;
	localparam int SEED = 60807;

	logic clk;
	logic reset_n;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic [WORD_SIZE-1:0] output_port;
	logic output_valid;
	logic [WORD_SIZE-1:0] num_inst;
	logic is_halted;

	logic [WORD_SIZE-1:0] image [MEM_WORDS];   // Program and data before the run
	logic [WORD_SIZE-1:0] ref_mem [MEM_WORDS]; // Memory after the ISA-level run
	logic [WORD_SIZE-1:0] wwd_expected [$];
	int ref_count;
	bit ref_halted;

	cpu_top UUT (
		.clk (clk),
		.reset_n (reset_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.output_port (output_port),
		.output_valid (output_valid),
		.num_inst (num_inst),
		.is_halted (is_halted)
	);

	wb_memory mem (
		.clk (clk),
		.reset_n (reset_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic stop_on_failure();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic report_problem(input string what);
		$display("ERROR at %t: %s", $time, what);
		stop_on_failure();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("[ERROR] %t: %s got 0x%0h, expected 0x%0h", $time, name, got, expected);
			stop_on_failure();
		end
	endtask

	function automatic logic [15:0] rtype_word(func_t f, logic [1:0] rs, logic [1:0] rt,
			logic [1:0] rd);
		return {OP_RTYPE, rs, rt, rd, f};
	endfunction

	function automatic logic [15:0] itype_word(opcode_t op, logic [1:0] rs, logic [1:0] rt,
			logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] jump_word(opcode_t op, logic [11:0] target);
		return {op, target};
	endfunction

	task automatic build_program();
		for (int i = 0; i < MEM_WORDS; i++)
			image[i] = 16'(i * 40503) ^ 16'hA5C3; // Background pattern
		image[256] = 16'h1234;
		image[257] = 16'h8001;
		image[0] = itype_word(OP_LHI, 2'd0, 2'd1, 8'h01); // r1 = 0x0100
		image[1] = itype_word(OP_LWD, 2'd1, 2'd2, 8'h00);
		image[2] = itype_word(OP_LWD, 2'd1, 2'd3, 8'h01);
		image[3] = rtype_word(FUNC_WWD, 2'd2, 2'd0, 2'd0);
		image[4] = rtype_word(FUNC_ADD, 2'd2, 2'd3, 2'd0);
		image[5] = rtype_word(FUNC_WWD, 2'd0, 2'd0, 2'd0);
		image[6] = rtype_word(FUNC_SUB, 2'd2, 2'd3, 2'd0);
		image[7] = rtype_word(FUNC_WWD, 2'd0, 2'd0, 2'd0);
		image[8] = rtype_word(FUNC_AND, 2'd2, 2'd3, 2'd0);
		image[9] = rtype_word(FUNC_WWD, 2'd0, 2'd0, 2'd0);
		image[10] = rtype_word(FUNC_ORR, 2'd2, 2'd3, 2'd0);
		image[11] = rtype_word(FUNC_WWD, 2'd0, 2'd0, 2'd0);
		image[12] = rtype_word(FUNC_NOT, 2'd2, 2'd0, 2'd0);
		image[13] = rtype_word(FUNC_WWD, 2'd0, 2'd0, 2'd0);
		image[14] = rtype_word(FUNC_TCP, 2'd3, 2'd0, 2'd0);
		image[15] = rtype_word(FUNC_WWD, 2'd0, 2'd0, 2'd0);
		image[16] = rtype_word(FUNC_SHL, 2'd3, 2'd0, 2'd0);
		image[17] = rtype_word(FUNC_WWD, 2'd0, 2'd0, 2'd0);
		image[18] = rtype_word(FUNC_SHR, 2'd3, 2'd0, 2'd0); // Negative operand
		image[19] = rtype_word(FUNC_WWD, 2'd0, 2'd0, 2'd0);
		image[20] = itype_word(OP_ADI, 2'd2, 2'd0, 8'hFD); // Add -3
		image[21] = rtype_word(FUNC_WWD, 2'd0, 2'd0, 2'd0);
		image[22] = itype_word(OP_ORI, 2'd1, 2'd0, 8'h35);
		image[23] = rtype_word(FUNC_WWD, 2'd0, 2'd0, 2'd0);
		image[24] = itype_word(OP_SWD, 2'd1, 2'd0, 8'h02);
		image[25] = itype_word(OP_SWD, 2'd1, 2'd2, 8'h03);
		image[26] = itype_word(OP_BEQ, 2'd2, 2'd3, 8'h05); // Not taken
		image[27] = itype_word(OP_BNE, 2'd2, 2'd3, 8'h01); // Taken
		image[28] = rtype_word(FUNC_WWD, 2'd3, 2'd0, 2'd0);
		image[29] = itype_word(OP_BGZ, 2'd2, 2'd0, 8'h01); // Taken
		image[30] = rtype_word(FUNC_WWD, 2'd3, 2'd0, 2'd0);
		image[31] = itype_word(OP_BGZ, 2'd3, 2'd0, 8'h01); // Not taken
		image[32] = itype_word(OP_BLZ, 2'd3, 2'd0, 8'h01); // Taken
		image[33] = rtype_word(FUNC_WWD, 2'd2, 2'd0, 2'd0);
		image[34] = itype_word(OP_BLZ, 2'd2, 2'd0, 8'h01); // Not taken
		image[35] = itype_word(OP_BEQ, 2'd2, 2'd2, 8'h01); // Taken
		image[36] = rtype_word(FUNC_WWD, 2'd3, 2'd0, 2'd0);
		image[37] = itype_word(OP_BNE, 2'd3, 2'd3, 8'h01); // Not taken
		image[38] = jump_word(OP_JMP, 12'd40);
		image[39] = rtype_word(FUNC_WWD, 2'd3, 2'd0, 2'd0);
		image[40] = jump_word(OP_JAL, 12'd50);
		image[41] = itype_word(OP_LHI, 2'd0, 2'd1, 8'h00);
		image[42] = itype_word(OP_ADI, 2'd1, 2'd1, 8'h37); // r1 = 55
		image[43] = rtype_word(FUNC_JRL, 2'd1, 2'd0, 2'd0);
		image[44] = itype_word(OP_LHI, 2'd0, 2'd0, 8'h01);
		image[45] = itype_word(OP_SWD, 2'd0, 2'd3, 8'h04);
		image[46] = rtype_word(FUNC_WWD, 2'd1, 2'd0, 2'd0);
		image[47] = rtype_word(FUNC_HLT, 2'd0, 2'd0, 2'd0);
		image[50] = rtype_word(FUNC_WWD, 2'd2, 2'd0, 2'd0); // Link value from JAL
		image[51] = rtype_word(FUNC_JPR, 2'd2, 2'd0, 2'd0);
		image[55] = rtype_word(FUNC_WWD, 2'd2, 2'd0, 2'd0); // Link value from JRL
		image[56] = rtype_word(FUNC_JPR, 2'd2, 2'd0, 2'd0);
	endtask

	// ISA-level model of the program with one instruction per loop pass
	function automatic void run_reference();
		logic [15:0] regs [4];
		logic [15:0] pc;
		logic [15:0] ir;
		logic [15:0] imm;
		logic [15:0] next_pc;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		int steps;
		for (int i = 0; i < MEM_WORDS; i++)
			ref_mem[i] = image[i];
		for (int i = 0; i < 4; i++)
			regs[i] = 16'h0000;
		pc = 16'h0000;
		steps = 0;
		ref_count = 0;
		ref_halted = 1'b0;
		wwd_expected.delete();
		while (!ref_halted && steps < 10000) begin
			ir = ref_mem[pc[9:0]];
			rs = ir[11:10];
			rt = ir[9:8];
			rd = ir[7:6];
			imm = {{8{ir[7]}}, ir[7:0]};
			next_pc = pc + 16'd1;
			steps++;
			case (ir[15:12])
				OP_BNE: if (regs[rs] != regs[rt]) next_pc = pc + 16'd1 + imm;
				OP_BEQ: if (regs[rs] == regs[rt]) next_pc = pc + 16'd1 + imm;
				OP_BGZ: if ($signed(regs[rs]) > 16'sd0) next_pc = pc + 16'd1 + imm;
				OP_BLZ: if ($signed(regs[rs]) < 16'sd0) next_pc = pc + 16'd1 + imm;
				OP_ADI: regs[rt] = regs[rs] + imm;
				OP_ORI: regs[rt] = regs[rs] | imm;
				OP_LHI: regs[rt] = {ir[7:0], 8'h00};
				OP_LWD: regs[rt] = ref_mem[10'(regs[rs] + imm)];
				OP_SWD: ref_mem[10'(regs[rs] + imm)] = regs[rt];
				OP_JMP: next_pc = {pc[15:12], ir[11:0]};
				OP_JAL: begin
					regs[2] = pc + 16'd1;
					next_pc = {pc[15:12], ir[11:0]};
				end
				OP_RTYPE: begin
					case (ir[5:0])
						FUNC_ADD: regs[rd] = regs[rs] + regs[rt];
						FUNC_SUB: regs[rd] = regs[rs] - regs[rt];
						FUNC_AND: regs[rd] = regs[rs] & regs[rt];
						FUNC_ORR: regs[rd] = regs[rs] | regs[rt];
						FUNC_NOT: regs[rd] = ~regs[rs];
						FUNC_TCP: regs[rd] = 16'd0 - regs[rs];
						FUNC_SHL: regs[rd] = regs[rs] << 1;
						FUNC_SHR: regs[rd] = 16'($signed(regs[rs]) >>> 1);
						FUNC_WWD: wwd_expected.push_back(regs[rs]);
						FUNC_JPR: next_pc = regs[rs];
						FUNC_JRL: begin
							next_pc = regs[rs]; // Target read before the link write
							regs[2] = pc + 16'd1;
						end
						FUNC_HLT: ref_halted = 1'b1;
						default: ;
					endcase
				end
				default: ;
			endcase
			if (!ref_halted) begin
				ref_count++; // HLT itself is not counted
				pc = next_pc;
			end
		end
	endfunction

	initial begin : stimulus
		$timeformat(-9, 0, " ns", 12);
		void'($urandom(SEED));
		reset_n = 1'b0;
		build_program();
		for (int i = 0; i < MEM_WORDS; i++)
			mem.words[i] = image[i];
		run_reference();
		repeat (5) @(posedge clk);
		#10;
		check_value("wb_req.cyc", 32'(wb_req.cyc), 32'd0);
		check_value("wb_req.stb", 32'(wb_req.stb), 32'd0);
		check_value("output_valid", 32'(output_valid), 32'd0);
		check_value("is_halted", 32'(is_halted), 32'd0);
		check_value("num_inst", 32'(num_inst), 32'd0);
		reset_n = 1'b1;
	end

	initial begin : compare_outputs
		int idle;
		int wwd_index;
		logic [WORD_SIZE-1:0] halt_count;
		idle = 0;
		wwd_index = 0;
		while (reset_n !== 1'b1) begin
			@(negedge clk);
			idle++;
			if (idle > TIMEOUT_CYCLES)
				report_problem("reset_n was never released");
		end
		idle = 0;
		while (is_halted !== 1'b1) begin
			@(negedge clk);
			if (output_valid) begin
				if (wwd_index >= wwd_expected.size())
					report_problem("output_valid pulsed more often than the program has WWDs");
				else
					check_value($sformatf("output_port (WWD %0d)", wwd_index),
						32'(output_port), 32'(wwd_expected[wwd_index]));
				wwd_index++;
				idle = 0;
			end else begin
				if (wwd_index > 0)
					check_value("output_port between WWDs", 32'(output_port),
						32'(wwd_expected[wwd_index-1]));
				idle++;
				if (idle > TIMEOUT_CYCLES)
					report_problem("neither output_valid nor is_halted came within 5000 cycles");
			end
		end
		check_value("number of WWD outputs", 32'(wwd_index), 32'(wwd_expected.size()));
		check_value("num_inst at halt", 32'(num_inst), 32'(ref_count));
		halt_count = num_inst;
		repeat (50) begin
			@(negedge clk);
			check_value("wb_req.cyc after halt", 32'(wb_req.cyc), 32'd0);
			check_value("num_inst after halt", 32'(num_inst), 32'(halt_count));
		end
		for (int i = 0; i < MEM_WORDS; i++)
			check_value($sformatf("memory word %0d", i), 32'(mem.words[i]), 32'(ref_mem[i]));
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/wb_memory.sv
`default_nettype none

module wb_memory import cpu_pkg::*; (
	input wire clk,
	input wire reset_n,
	input wire wb_req_t wb_req,
	output wb_rsp_t wb_rsp
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DEPTH = 1024;

	logic [WORD_SIZE-1:0] words [DEPTH]; // Filled by the testbench
	logic busy;
	logic [1:0] delay_left;
	logic [9:0] index;

	assign index = wb_req.adr[9:0]; // Word address with the upper bits ignored

	initial wb_rsp = '0;

	always @(posedge clk) begin : serve
		int unsigned wait_cycles;
		logic respond;
		respond = 1'b0;
		wait_cycles = 0;
		if (!reset_n) begin
			wb_rsp.ack <= 1'b0;
			busy <= 1'b0;
			delay_left <= '0;
		end else begin
			wb_rsp.ack <= 1'b0;
			if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
				if (!busy) begin
					wait_cycles = $urandom % 4; // 0 to 3 extra cycles
					respond = (wait_cycles == 0);
					busy <= (wait_cycles != 0);
					delay_left <= 2'(wait_cycles - 1);
				end else if (delay_left != 2'd0) begin
					delay_left <= delay_left - 2'd1;
				end else begin
					busy <= 1'b0;
					respond = 1'b1;
				end
			end
			if (respond) begin
				wb_rsp.ack <= 1'b1; // Single-cycle ack
				if (wb_req.we)
					words[index] <= wb_req.dat_w;
				else
					wb_rsp.dat_r <= words[index];
			end
		end
	end

endmodule

`default_nettype wire

//--- source/cpu_top.sv
`default_nettype none

module cpu_top import cpu_pkg::*; (
	input wire clk,
	input wire reset_n,
	output wb_req_t wb_req,
	input wire wb_rsp_t wb_rsp,
	output logic [WORD_SIZE-1:0] output_port,
	output logic output_valid,
	output logic [WORD_SIZE-1:0] num_inst,
	output logic is_halted
);

	ctrl_t ctrl;
	micro_step_t micro_step;
	logic bus_req;
	logic bus_we;
	logic bus_done;
	logic ir_load;
	logic pc_update;
	logic reg_commit;
	logic mdr_load;
	logic [WORD_SIZE-1:0] instr;
	logic [WORD_SIZE-1:0] mem_addr;
	logic [WORD_SIZE-1:0] mem_wdata;
	logic [WORD_SIZE-1:0] rd_data;

	control_unit u_control (
		.clk (clk),
		.reset_n (reset_n),
		.instr (instr),
		.bus_done (bus_done),
		.ctrl (ctrl),
		.micro_step (micro_step),
		.bus_req (bus_req),
		.bus_we (bus_we),
		.bus_instr (),
		.ir_load (ir_load),
		.pc_update (pc_update),
		.reg_commit (reg_commit),
		.mdr_load (mdr_load),
		.num_inst (num_inst),
		.is_halted (is_halted)
	);

	datapath u_datapath (
		.clk (clk),
		.reset_n (reset_n),
		.ctrl (ctrl),
		.micro_step (micro_step),
		.ir_load (ir_load),
		.pc_update (pc_update),
		.reg_commit (reg_commit),
		.mdr_load (mdr_load),
		.rd_data (rd_data),
		.instr (instr),
		.mem_addr (mem_addr),
		.mem_wdata (mem_wdata),
		.output_port (output_port),
		.output_valid (output_valid)
	);

	wb_master u_wb_master (
		.clk (clk),
		.reset_n (reset_n),
		.bus_req (bus_req),
		.bus_we (bus_we),
		.addr (mem_addr),
		.wdata (mem_wdata),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.bus_done (bus_done),
		.rd_data (rd_data)
	);

endmodule

`default_nettype wire

//--- source/wb_master.sv
`default_nettype none

module wb_master import cpu_pkg::*; (
	input wire clk,
	input wire reset_n,
	input wire bus_req,
	input wire bus_we,
	input wire [WORD_SIZE-1:0] addr,
	input wire [WORD_SIZE-1:0] wdata,
	output wb_req_t wb_req,
	input wire wb_rsp_t wb_rsp,
	output logic bus_done,
	output logic [WORD_SIZE-1:0] rd_data
);

	logic cyc;
	logic gap; // Idle cycle after each ack
	logic we_q;
	logic [WORD_SIZE-1:0] adr_q;
	logic [WORD_SIZE-1:0] dat_q;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cyc <= 1'b0;
			gap <= 1'b0;
		end else begin
			gap <= 1'b0;
			if (cyc) begin
				if (wb_rsp.ack) begin
					cyc <= 1'b0;
					gap <= 1'b1;
				end
			end else if (bus_req && !gap) begin
				cyc <= 1'b1;
			end
		end
	end

	// Address and data held for the whole cycle
	always_ff @(posedge clk) begin
		if (!cyc && bus_req && !gap) begin
			we_q <= bus_we;
			adr_q <= addr;
			dat_q <= wdata;
		end
	end

	always_comb begin
		wb_req.cyc = cyc;
		wb_req.stb = cyc;
		wb_req.we = we_q;
		wb_req.adr = adr_q;
		wb_req.dat_w = dat_q;
	end

	assign bus_done = cyc && wb_rsp.ack;
	assign rd_data = wb_rsp.dat_r;

endmodule

`default_nettype wire

//--- control/control_unit.sv
`default_nettype none

module control_unit import cpu_pkg::*; (
	input wire clk,
	input wire reset_n,
	input wire [WORD_SIZE-1:0] instr,
	input wire bus_done,
	output ctrl_t ctrl,
	output micro_step_t micro_step,
	output logic bus_req,
	output logic bus_we,
	output logic bus_instr,
	output logic ir_load,
	output logic pc_update,
	output logic reg_commit,
	output logic mdr_load,
	output logic [WORD_SIZE-1:0] num_inst,
	output logic is_halted
);

	opcode_t opcode;
	func_t func;
	micro_step_t next_step;
	logic is_hlt;
	logic direct_jump;
	logic retire;

	assign opcode = opcode_t'(instr[15:12]);
	assign func = func_t'(instr[5:0]);
	assign is_hlt = (opcode == OP_RTYPE) && (func == FUNC_HLT);
	assign direct_jump = (opcode == OP_JMP) || (opcode == OP_JAL);

	always_comb begin
		ctrl = '0;
		case (opcode)
			OP_RTYPE: begin
				case (func)
					FUNC_ADD, FUNC_SUB, FUNC_AND, FUNC_ORR,
					FUNC_NOT, FUNC_TCP, FUNC_SHL, FUNC_SHR: ctrl.reg_write = 1'b1;
					FUNC_JPR: begin
						ctrl.pc_jump = 1'b1;
						ctrl.pc_from_reg = 1'b1;
						ctrl.alu_op = ALU_ZERO;
					end
					FUNC_JRL: begin
						ctrl.pc_jump = 1'b1;
						ctrl.pc_from_reg = 1'b1;
						ctrl.link = 1'b1;
						ctrl.reg_write = 1'b1;
						ctrl.alu_op = ALU_ZERO;
					end
					FUNC_WWD: ctrl.wwd_en = 1'b1;
					default: ctrl = '0; // HLT and unused codes
				endcase
				case (func)
					FUNC_ADD: ctrl.alu_op = ALU_ADD;
					FUNC_SUB: ctrl.alu_op = ALU_SUB;
					FUNC_AND: ctrl.alu_op = ALU_AND;
					FUNC_ORR: ctrl.alu_op = ALU_OR;
					FUNC_NOT: ctrl.alu_op = ALU_NOT;
					FUNC_TCP: ctrl.alu_op = ALU_TCP;
					FUNC_SHL: ctrl.alu_op = ALU_ALS;
					FUNC_SHR: ctrl.alu_op = ALU_ARS;
					default: ;
				endcase
			end
			OP_ADI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = ALU_ADD;
				ctrl.alu_src_imm = 1'b1;
			end
			OP_ORI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = ALU_OR;
				ctrl.alu_src_imm = 1'b1;
			end
			OP_LHI: begin
				ctrl.lhi = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = ALU_ZERO;
			end
			OP_LWD: begin
				ctrl.mem_read = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = ALU_ADD; // rs + imm
				ctrl.alu_src_imm = 1'b1;
			end
			OP_SWD: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_op = ALU_ADD;
				ctrl.alu_src_imm = 1'b1;
			end
			OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
				ctrl.pc_branch = 1'b1;
				ctrl.alu_op = ALU_SUB; // rs against rt, target built in datapath
			end
			OP_JMP: begin
				ctrl.pc_jump = 1'b1;
				ctrl.alu_op = ALU_ZERO;
			end
			OP_JAL: begin
				ctrl.pc_jump = 1'b1;
				ctrl.link = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = ALU_ZERO;
			end
			default: ctrl = '0;
		endcase
	end

	// Step sequencing, with the retire cycle marked
	always_comb begin
		next_step = micro_step;
		retire = 1'b0;
		case (micro_step)
			STEP_IF: if (bus_done) next_step = direct_jump ? STEP_EX : STEP_ID;
			STEP_ID: next_step = STEP_EX;
			STEP_EX: begin
				if (is_hlt) begin
					next_step = STEP_EX; // Parked here once halted
				end else if (ctrl.pc_branch || ctrl.wwd_en) begin
					retire = 1'b1;
					next_step = STEP_IF;
				end else if (ctrl.mem_read || ctrl.mem_write) begin
					next_step = STEP_MEM;
				end else begin
					next_step = STEP_WB;
				end
			end
			STEP_MEM: begin
				if (bus_done) begin
					retire = ctrl.mem_write; // Store ends here
					next_step = ctrl.mem_write ? STEP_IF : STEP_WB;
				end
			end
			STEP_WB: begin
				retire = 1'b1;
				next_step = STEP_IF;
			end
			default: next_step = STEP_IF;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			micro_step <= STEP_IF;
			num_inst <= '0;
			is_halted <= 1'b0;
		end else if (!is_halted) begin
			micro_step <= next_step;
			if (retire)
				num_inst <= num_inst + WORD_SIZE'(1);
			if (micro_step == STEP_EX && is_hlt)
				is_halted <= 1'b1; // HLT itself is not counted
		end
	end

	assign bus_instr = (micro_step == STEP_IF);
	assign bus_req = !is_halted && (bus_instr || micro_step == STEP_MEM);
	assign bus_we = (micro_step == STEP_MEM) && ctrl.mem_write;
	assign ir_load = bus_instr && bus_done;
	assign mdr_load = (micro_step == STEP_MEM) && bus_done && ctrl.mem_read;
	assign pc_update = retire;
	assign reg_commit = (micro_step == STEP_WB) && ctrl.reg_write;

endmodule

`default_nettype wire

//--- datapath/datapath.sv
`default_nettype none

module datapath import cpu_pkg::*; (
	input wire clk,
	input wire reset_n,
	input wire ctrl_t ctrl,
	input wire micro_step_t micro_step,
	input wire ir_load,
	input wire pc_update,
	input wire reg_commit,
	input wire mdr_load,
	input wire [WORD_SIZE-1:0] rd_data,
	output logic [WORD_SIZE-1:0] instr,
	output logic [WORD_SIZE-1:0] mem_addr,
	output logic [WORD_SIZE-1:0] mem_wdata,
	output logic [WORD_SIZE-1:0] output_port,
	output logic output_valid
);

	logic [WORD_SIZE-1:0] pc;
	logic [WORD_SIZE-1:0] ir;
	logic [WORD_SIZE-1:0] mdr;
	logic [WORD_SIZE-1:0] out_reg;
	logic [WORD_SIZE-1:0] regs [NUM_REGS];

	opcode_t opcode;
	logic [1:0] rs;
	logic [1:0] rt;
	logic [1:0] rd;
	logic [1:0] dest;
	logic [WORD_SIZE-1:0] imm_ext;
	logic [WORD_SIZE-1:0] jump_target;
	logic [WORD_SIZE-1:0] pc_plus1;
	logic [WORD_SIZE-1:0] next_pc;
	logic [WORD_SIZE-1:0] wr_data;
	logic [WORD_SIZE-1:0] op_b;
	logic [WORD_SIZE-1:0] alu_result;
	logic branch_taken;

	assign opcode = opcode_t'(ir[15:12]);
	assign rs = ir[11:10];
	assign rt = ir[9:8];
	assign rd = ir[7:6];
	assign imm_ext = {{(WORD_SIZE-8){ir[7]}}, ir[7:0]};
	assign jump_target = {pc[WORD_SIZE-1:12], ir[11:0]};
	assign pc_plus1 = pc + WORD_SIZE'(1);

	// Decoder sees the fetched word already in its ack cycle
	assign instr = ir_load ? rd_data : ir;

	assign op_b = ctrl.alu_src_imm ? imm_ext : regs[rt];

	alu u_alu (
		.op_a (regs[rs]),
		.op_b (op_b),
		.alu_op (ctrl.alu_op),
		.opcode (opcode),
		.result (alu_result),
		.branch_taken (branch_taken)
	);

	always_comb begin
		if (ctrl.pc_jump)
			next_pc = ctrl.pc_from_reg ? regs[rs] : jump_target;
		else if (ctrl.pc_branch && branch_taken)
			next_pc = pc_plus1 + imm_ext;
		else
			next_pc = pc_plus1;
	end

	// R-type writes rd, I-type writes rt, links go to register 2
	always_comb begin
		if (ctrl.link)
			dest = 2'd2;
		else if (opcode == OP_RTYPE)
			dest = rd;
		else
			dest = rt;
	end

	always_comb begin
		if (ctrl.link)
			wr_data = pc_plus1;
		else if (ctrl.lhi)
			wr_data = {ir[7:0], 8'h00};
		else if (ctrl.mem_read)
			wr_data = mdr;
		else
			wr_data = alu_result;
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			ir <= '0;
		end else begin
			if (pc_update)
				pc <= next_pc;
			if (ir_load)
				ir <= rd_data;
		end
	end

	always_ff @(posedge clk) begin
		if (mdr_load)
			mdr <= rd_data;
		if (reg_commit)
			regs[dest] <= wr_data;
		if (output_valid)
			out_reg <= regs[rs];
	end

	assign mem_addr = (micro_step == STEP_MEM) ? alu_result : pc;
	assign mem_wdata = regs[rt];

	assign output_valid = (micro_step == STEP_EX) && ctrl.wwd_en;
	assign output_port = output_valid ? regs[rs] : out_reg; // Value visible in the EX cycle

endmodule

`default_nettype wire

//--- datapath/alu.sv
`default_nettype none

module alu import cpu_pkg::*; (
	input wire [WORD_SIZE-1:0] op_a,
	input wire [WORD_SIZE-1:0] op_b,
	input wire alu_op_t alu_op,
	input wire opcode_t opcode,
	output logic [WORD_SIZE-1:0] result,
	output logic branch_taken
);

	always_comb begin
		case (alu_op)
			ALU_ADD: result = op_a + op_b;
			ALU_SUB: result = op_a - op_b;
			ALU_AND: result = op_a & op_b;
			ALU_OR: result = op_a | op_b;
			ALU_NOT: result = ~op_a;
			ALU_TCP: result = ~op_a + WORD_SIZE'(1); // Two's complement
			ALU_ALS: result = {op_a[WORD_SIZE-2:0], 1'b0};
			ALU_ARS: result = {op_a[WORD_SIZE-1], op_a[WORD_SIZE-1:1]}; // Sign kept
			default: result = '0;
		endcase
	end

	always_comb begin
		case (opcode)
			OP_BNE: branch_taken = (op_a != op_b);
			OP_BEQ: branch_taken = (op_a == op_b);
			OP_BGZ: branch_taken = ($signed(op_a) > 0);
			OP_BLZ: branch_taken = ($signed(op_a) < 0);
			default: branch_taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int WORD_SIZE = 16;
	localparam int NUM_REGS = 4;

	// Upper four bits of the instruction word
	typedef enum logic [3:0] {
		OP_BNE = 4'd0,
		OP_BEQ = 4'd1,
		OP_BGZ = 4'd2,
		OP_BLZ = 4'd3,
		OP_ADI = 4'd4,
		OP_ORI = 4'd5,
		OP_LHI = 4'd6,
		OP_LWD = 4'd7,
		OP_SWD = 4'd8,
		OP_JMP = 4'd9,
		OP_JAL = 4'd10,
		OP_RTYPE = 4'd15
	} opcode_t;

	// Low six bits of an R-type instruction
	typedef enum logic [5:0] {
		FUNC_ADD = 6'd0,
		FUNC_SUB = 6'd1,
		FUNC_AND = 6'd2,
		FUNC_ORR = 6'd3,
		FUNC_NOT = 6'd4,
		FUNC_TCP = 6'd5,
		FUNC_SHL = 6'd6,
		FUNC_SHR = 6'd7,
		FUNC_JPR = 6'd25,
		FUNC_JRL = 6'd26,
		FUNC_WWD = 6'd28,
		FUNC_HLT = 6'd29
	} func_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOT,
		ALU_TCP,
		ALU_ALS,
		ALU_ARS,
		ALU_ZERO
	} alu_op_t;

	typedef enum logic [2:0] {
		STEP_IF,
		STEP_ID,
		STEP_EX,
		STEP_MEM,
		STEP_WB
	} micro_step_t;

	typedef struct packed {
		logic wwd_en;      // Drive the output port
		logic pc_jump;     // PC takes jump target
		logic pc_branch;   // PC takes branch target if taken
		logic pc_from_reg; // Jump target is rs
		logic link;        // PC+1 into register 2
		logic lhi;         // Immediate into the upper half
		logic mem_read;
		logic mem_write;
		logic reg_write;
		alu_op_t alu_op;
		logic alu_src_imm; // Operand B from the immediate
	} ctrl_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [WORD_SIZE-1:0] adr;
		logic [WORD_SIZE-1:0] dat_w;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [WORD_SIZE-1:0] dat_r;
	} wb_rsp_t;

endpackage

`default_nettype wire
